/* build.f */
+incdir+.
seg_pkg.sv
pixel_timing_if.sv
raster_timer.sv
ycc_to_rgb.sv
rgb_to_hsv.sv
color_classify.sv
class_frame_store.sv
color_segmenter_top.sv
tb_color_segmenter.sv

/* Makefile */
# Verilator simulation of the colour segmenter

VERILATOR ?= verilator
TOP       ?= tb_color_segmenter
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST) > $(LOG) 2>&1
	./$(BUILD)/V$(TOP) >> $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test OK" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_color_segmenter.sv */
`timescale 1ns/1ps
`include "seg_cfg.svh"

module tb_color_segmenter import seg_pkg::*; ();

	localparam int HGAP      = 6;      // idle bytes between lines
	localparam int VGAP      = 12;     // idle cycles after a frame
	localparam int UNI_LINES = 4;
	localparam int UNI_MPS   = 8;
	localparam int RND_LINES = 6;      // short lines for the random frame
	localparam int RND_MPS   = 5;
	localparam int ALT_LINES = 6;
	localparam int ALT_MPS   = 6;
	localparam int MODE_UNI  = 0;
	localparam int MODE_RND  = 1;
	localparam int MODE_ALT  = 2;

	// model constants, ints so the arithmetic stays signed
	localparam int KY   = `K_Y;
	localparam int KCRR = `K_CR_R;
	localparam int KCRG = `K_CR_G;
	localparam int KCBG = `K_CB_G;
	localparam int KCBB = `K_CB_B;

	// cycles for one frame plus its readback
	function int frame_cost(input int lines, input int mps);
		return 4 + lines * (4 * mps + HGAP) + `CLASS_LATENCY + 4 + VGAP
			+ 2 * ((lines + 1) / 2) * mps + 8;
	endfunction

	localparam int CYCLE_LIMIT = 2 * (6 * frame_cost(UNI_LINES, UNI_MPS)
		+ frame_cost(RND_LINES, RND_MPS) + frame_cost(ALT_LINES, ALT_MPS)
		+ frame_cost(2, UNI_MPS)) + 200;

	// {cb, y, cr} test colours
	localparam logic [23:0] PIX_RED    = {8'd90,  8'd82,  8'd240};
	localparam logic [23:0] PIX_GREEN  = {8'd54,  8'd145, 8'd34};
	localparam logic [23:0] PIX_BLUE   = {8'd240, 8'd41,  8'd110};
	localparam logic [23:0] PIX_YELLOW = {8'd16,  8'd210, 8'd146};
	localparam logic [23:0] PIX_GREY   = {8'd128, 8'd40,  8'd128};

	logic      clk_llc;
	logic      resetx;
	logic      vref;
	logic      href;
	byte_t     vpo;
	pix_addr_t host_addr;
	mask_t     host_data;
	logic      frame_done;

	integer    seed;
	int        cycles;
	int        n_exp;               // class words expected this frame
	int        wr_cnt;              // writes seen this frame
	logic      done_exp;            // expected frame_done level
	class_t    exp_cls [0:255];

	color_segmenter_top i_color_segmenter_top (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.vref       (vref),
		.href       (href),
		.vpo        (vpo),
		.host_addr  (host_addr),
		.host_data  (host_data),
		.frame_done (frame_done)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever
			#2 clk_llc = ~clk_llc;
	end

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic int clamp_chan(input int sum);
		if (sum < 0)
			return 0;
		else if (sum >= 262144)
			return 255;     // 2^18 and up saturates
		return sum / 1024;
	endfunction

	function automatic logic in_hue(input int h, input int centre);
		int lo;
		int hi;
		lo = (centre - `HUE_TOL) & 255;    // 8 bit wrap
		hi = (centre + `HUE_TOL) & 255;
		return (h >= lo) && (h <= hi);
	endfunction

	function automatic class_t ref_class(input logic [23:0] pix);
		int   yd, cbd, crd;
		int   r, g, b, mx, mn, dl, h, s, v;
		logic blk, hi, lo;
		yd  = int'(pix[15:8]) * 4 - `Y_OFS;
		cbd = int'(pix[23:16]) * 4 - `C_OFS;
		crd = int'(pix[7:0]) * 4 - `C_OFS;
		r   = clamp_chan(KY * yd + KCRR * crd);
		g   = clamp_chan(KY * yd - KCRG * crd - KCBG * cbd);
		b   = clamp_chan(KY * yd + KCBB * cbd);
		mn  = (r < g) ? r : g;
		mn  = (b < mn) ? b : mn;
		mx  = (r >= g && r >= b) ? r : ((g >= b) ? g : b);
		dl  = mx - mn;
		if (dl == 0)
			h = 0;
		else if (r >= g && r >= b)
			h = (40 * (g - b) / dl + 240) % 240;
		else if (g >= b)
			h = 40 * (b - r) / dl + 80;
		else
			h = 40 * (r - g) / dl + 160;
		s   = (mx == 0) ? 0 : dl * 255 / mx;
		v   = mx;
		blk = (s < 96) && (v < 96);
		hi  = !blk && (s > 96);
		lo  = !blk && (s > 36);
		return {lo && in_hue(h, `HUE_R), lo && in_hue(h, `HUE_O), lo && in_hue(h, `HUE_Y),
			lo && in_hue(h, `HUE_G), hi && in_hue(h, `HUE_B), blk};
	endfunction

	// host word, bit 15 down
	function automatic mask_t ref_mask(input class_t c);
		logic cr, co, cy, cg, cb, ck;
		{cr, co, cy, cg, cb, ck} = c;
		return {cr | co | cy, cr | co | cy | ck, cr, co, cy, cg | cy,
			cg | cy | co | ck, cg | cy | co, cg, cg, cg, cb, cb | ck, cb, cb, ck};
	endfunction

	// ------------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------------
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic compare_mask(input string name, input mask_t got, input mask_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_class(input string name, input class_t got, input class_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_addr(input string name, input pix_addr_t got, input pix_addr_t exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
	endtask

	// write port and frame_done watched mid cycle
	always @(negedge clk_llc)
	begin
		if (resetx)
		begin
			compare_flag("frame_done", frame_done, done_exp);
			if (i_color_segmenter_top.tm_if.wr_en)
			begin
				compare_addr("wr_addr", i_color_segmenter_top.tm_if.wr_addr, pix_addr_t'(wr_cnt));
				compare_class("cls", i_color_segmenter_top.cls, exp_cls[wr_cnt]);
				wr_cnt++;
			end
		end
	end

	always @(posedge clk_llc)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			abort_run($sformatf("timeout, tests still running after %0d cycles", cycles));
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	task automatic put_byte(input byte_t d);
		@(posedge clk_llc);
		#1;
		href = 1'b1;
		vpo  = d;
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk_llc);
			#1;
			href = 1'b0;
			vpo  = 8'h10;
		end
	endtask

	// one frame, even lines are the kept ones
	task automatic drive_frame(input int lines, input int mps, input int mode,
		input logic [23:0] pix_a, input logic [23:0] pix_b);
		logic [23:0] pix;
		byte_t       y1;
		n_exp  = 0;
		wr_cnt = 0;
		@(posedge clk_llc);
		#1;
		vref = 1'b1;
		idle(4);
		for (int ln = 0; ln < lines; ln++)
		begin
			for (int mp = 0; mp < mps; mp++)
			begin
				if (mode == MODE_RND)
					pix = 24'($random(seed));
				else if (mode == MODE_ALT && ln % 2 == 1)
					pix = pix_b;
				else
					pix = pix_a;
				y1 = byte_t'($random(seed));   // second luma is ignored
				if (ln % 2 == 0)
				begin
					exp_cls[n_exp] = ref_class(pix);
					n_exp++;
				end
				put_byte(pix[23:16]);
				put_byte(pix[15:8]);
				put_byte(pix[7:0]);
				put_byte(y1);
			end
			idle(HGAP);
		end
		@(posedge clk_llc);
		#1;
		vref = 1'b0;
		@(posedge clk_llc);                          // vref seen low here
		repeat (`CLASS_LATENCY + 1) @(posedge clk_llc);
		#1;
		done_exp = 1'b1;
		@(posedge clk_llc);
		#1;
		done_exp = 1'b0;
		idle(VGAP);
		if (wr_cnt != n_exp)
			abort_run($sformatf("frame wrote %0d words instead of %0d", wr_cnt, n_exp));
	endtask

	task automatic read_frame(input int n);
		for (int a = 0; a < n; a++)
		begin
			@(posedge clk_llc);
			#1;
			host_addr = pix_addr_t'(a);
			@(posedge clk_llc);
			@(negedge clk_llc);
			compare_mask("host_data", host_data, ref_mask(exp_cls[a]));
		end
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_quiet();
		$display("frame_done after reset");
		idle(40);                   // monitor holds frame_done low
	endtask

	task automatic test_uniform();
		logic [23:0] cols [5];
		cols = '{PIX_RED, PIX_GREEN, PIX_BLUE, PIX_YELLOW, PIX_GREY};
		$display("uniform colour frames");
		foreach (cols[i])
		begin
			drive_frame(UNI_LINES, UNI_MPS, MODE_UNI, cols[i], cols[i]);
			read_frame(n_exp);
		end
	endtask

	task automatic test_random();
		$display("random frame, short lines");
		drive_frame(RND_LINES, RND_MPS, MODE_RND, '0, '0);
		read_frame(n_exp);
	endtask

	task automatic test_decimation();
		$display("line decimation");
		if (ref_class(PIX_RED) == ref_class(PIX_BLUE))
			abort_run("decimation colours give the same class");
		drive_frame(ALT_LINES, ALT_MPS, MODE_ALT, PIX_RED, PIX_BLUE);
		read_frame(n_exp);
	endtask

	task automatic test_second_frame();
		$display("frame_done and overwrite from address 0");
		drive_frame(UNI_LINES, UNI_MPS, MODE_UNI, PIX_GREEN, PIX_GREEN);
		drive_frame(2, UNI_MPS, MODE_UNI, PIX_YELLOW, PIX_YELLOW);
		read_frame(n_exp);
	endtask

	initial
	begin
		seed       = 32'hcba0b95f;
		cycles     = 0;
		n_exp      = 0;
		wr_cnt     = 0;
		done_exp   = 1'b0;
		resetx     = 1'b0;
		vref       = 1'b0;
		href       = 1'b0;
		vpo        = 8'h10;
		host_addr  = '0;
		repeat (10) @(posedge clk_llc);
		#1;
		resetx = 1'b1;
		test_reset_quiet();
		test_uniform();
		test_random();
		test_decimation();
		test_second_frame();
		$display("Test OK");
		$finish;
	end

endmodule

/* color_segmenter_top.sv */
`timescale 1ns/1ps

module color_segmenter_top import seg_pkg::*; (
	input  logic      clk_llc,
	input  logic      resetx,
	input  logic      vref,         // vertical sync
	input  logic      href,         // horizontal sync
	input  byte_t     vpo,          // 4:2:2 bytes, Cb Y0 Cr Y1
	input  pix_addr_t host_addr,
	output mask_t     host_data,
	output logic      frame_done
);

	pixel_timing_if tm_if ();

	chan_t  r, g, b;        // after 2 cycles
	chan_t  h, s, v;        // after 5 cycles
	class_t cls;            // after CLASS_LATENCY cycles

	// ------------------------------------------------------------------------
	// raster timing beside the colour chain
	// ------------------------------------------------------------------------
	raster_timer i_raster_timer (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.vref       (vref),
		.href       (href),
		.tm         (tm_if.timer),
		.frame_done (frame_done)
	);

	ycc_to_rgb i_ycc_to_rgb (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.vpo     (vpo),
		.tm      (tm_if.chain),
		.r       (r),
		.g       (g),
		.b       (b)
	);

	rgb_to_hsv i_rgb_to_hsv (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.r       (r),
		.g       (g),
		.b       (b),
		.h       (h),
		.s       (s),
		.v       (v)
	);

	color_classify i_color_classify (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.h       (h),
		.s       (s),
		.v       (v),
		.cls     (cls)
	);

	// class word meets its delayed write address here
	class_frame_store i_class_frame_store (
		.clk_llc   (clk_llc),
		.cls       (cls),
		.st        (tm_if.store),
		.host_addr (host_addr),
		.host_data (host_data)
	);

endmodule

/* class_frame_store.sv */
`timescale 1ns/1ps
`include "seg_cfg.svh"

module class_frame_store import seg_pkg::*; (
	input  logic          clk_llc,
	input  class_t        cls,
	pixel_timing_if.store st,
	input  pix_addr_t     host_addr,
	output mask_t         host_data
);

	class_t mem [0:`FRAME_PIXELS-1];    // one class word per stored pixel
	class_t rd_q;

	logic c_r, c_o, c_y, c_g, c_b, c_bk;

	// write from the chain, host read registered, old data on collision
	always_ff @(posedge clk_llc)
	begin
		if (st.wr_en)
			mem[st.wr_addr] <= cls;
		rd_q <= mem[host_addr];
	end

	assign {c_r, c_o, c_y, c_g, c_b, c_bk} = rd_q;

	// ------------------------------------------------------------------------
	// group mask for the host, bit 15 down
	// ------------------------------------------------------------------------
	assign host_data[15] = c_r | c_o | c_y;            // roy
	assign host_data[14] = c_r | c_o | c_y | c_bk;     // roy or black
	assign host_data[13] = c_r;
	assign host_data[12] = c_o;
	assign host_data[11] = c_y;
	assign host_data[10] = c_g | c_y;                  // gy
	assign host_data[9]  = c_g | c_y | c_o | c_bk;     // gyo or black
	assign host_data[8]  = c_g | c_y | c_o;            // gyo
	assign host_data[7]  = c_g;
	assign host_data[6]  = c_g;
	assign host_data[5]  = c_g;
	assign host_data[4]  = c_b;
	assign host_data[3]  = c_b | c_bk;                 // blue or black
	assign host_data[2]  = c_b;
	assign host_data[1]  = c_b;
	assign host_data[0]  = c_bk;

	a_host_addr_range: assert property (@(posedge clk_llc)
		!$isunknown(host_addr) |-> (host_addr < `FRAME_PIXELS))
		else $error("host_addr beyond class memory");

endmodule

/* color_classify.sv */
`timescale 1ns/1ps
`include "seg_cfg.svh"

module color_classify import seg_pkg::*; (
	input  logic   clk_llc,
	input  logic   resetx,
	input  chan_t  h,
	input  chan_t  s,
	input  chan_t  v,
	output class_t cls
);

	logic  black_c;
	logic  black_q;
	logic  chroma_hi_q;     // strong colour, used by blue
	logic  chroma_lo_q;     // weak colour is enough for the rest
	chan_t h_q;             // hue, one stage behind to match the flags

	// centre +- tolerance, bounds wrap at 8 bits, limits inclusive
	function automatic logic in_window(input chan_t hue, input chan_t centre);
		chan_t lo;
		chan_t hi;
		lo = centre - `HUE_TOL;
		hi = centre + `HUE_TOL;
		return (hue >= lo) && (hue <= hi);
	endfunction

	assign black_c = (s < `S_THRES_HI) && (v < `V_THRES);   // dark and grey

	// ------------------------------------------------------------------------
	// stage 1 flags, stage 2 hue windows
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			black_q     <= 1'b0;
			chroma_hi_q <= 1'b0;
			chroma_lo_q <= 1'b0;
			h_q         <= '0;
		end
		else
		begin
			black_q     <= black_c;
			chroma_hi_q <= !black_c && (s > `S_THRES_HI);
			chroma_lo_q <= !black_c && (s > `S_THRES_LO);
			h_q         <= h;
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			cls <= '0;
		else
		begin
			cls[5] <= chroma_lo_q && in_window(h_q, `HUE_R);   // red
			cls[4] <= chroma_lo_q && in_window(h_q, `HUE_O);   // orange
			cls[3] <= chroma_lo_q && in_window(h_q, `HUE_Y);   // yellow
			cls[2] <= chroma_lo_q && in_window(h_q, `HUE_G);   // green
			cls[1] <= chroma_hi_q && in_window(h_q, `HUE_B);   // blue
			cls[0] <= black_q;
		end
	end

endmodule

/* rgb_to_hsv.sv */
`timescale 1ns/1ps

module rgb_to_hsv import seg_pkg::*; (
	input  logic  clk_llc,
	input  logic  resetx,
	input  chan_t r,
	input  chan_t g,
	input  chan_t b,
	output chan_t h,
	output chan_t s,
	output chan_t v
);

	localparam logic [1:0] SEL_R = 2'd0;
	localparam logic [1:0] SEL_G = 2'd1;
	localparam logic [1:0] SEL_B = 2'd2;

	chan_t              max_c, min_c;
	logic [1:0]         sel_c;
	chan_t              r1, g1, b1, max1, min1;    // stage 1
	logic [1:0]         sel1;
	chan_t              delta2, max2;              // stage 2
	logic signed [8:0]  hdiff2;
	logic [1:0]         sel2;
	logic signed [15:0] hue_num, hue_quo, hue_c;
	logic [15:0]        sat_num;
	chan_t              sat_c;

	// max channel, ties go to R then G
	always_comb
	begin
		if (r >= g && r >= b)
		begin
			max_c = r;
			sel_c = SEL_R;
		end
		else if (g >= b)
		begin
			max_c = g;
			sel_c = SEL_G;
		end
		else
		begin
			max_c = b;
			sel_c = SEL_B;
		end
		min_c = r;
		if (g < min_c)
			min_c = g;
		if (b < min_c)
			min_c = b;
	end

	// ------------------------------------------------------------------------
	// stage 3 division
	// ------------------------------------------------------------------------
	always_comb
	begin
		hue_num = hdiff2 * 16'sd40;
		hue_quo = '0;
		hue_c   = '0;
		if (delta2 != 8'd0)
		begin
			hue_quo = hue_num / $signed({8'd0, delta2});   // truncates toward zero
			case (sel2)
				SEL_R:   hue_c = (hue_quo + 16'sd240) % 16'sd240;
				SEL_G:   hue_c = hue_quo + 16'sd80;
				default: hue_c = hue_quo + 16'sd160;
			endcase
		end
		sat_num = {8'd0, delta2} * 16'd255;
		if (max2 == 8'd0)
			sat_c = 8'd0;
		else
			sat_c = 8'(sat_num / {8'd0, max2});   // delta <= max keeps it in 8 bits
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			{r1, g1, b1, max1, min1} <= '0;
			sel1   <= SEL_R;
			delta2 <= '0;
			max2   <= '0;
			hdiff2 <= '0;
			sel2   <= SEL_R;
			h      <= '0;
			s      <= '0;
			v      <= '0;
		end
		else
		begin
			// stage 1, carry the channels for the hue difference
			r1   <= r;
			g1   <= g;
			b1   <= b;
			max1 <= max_c;
			min1 <= min_c;
			sel1 <= sel_c;
			// stage 2
			delta2 <= max1 - min1;
			max2   <= max1;
			sel2   <= sel1;
			case (sel1)
				SEL_R:   hdiff2 <= $signed({1'b0, g1}) - $signed({1'b0, b1});
				SEL_G:   hdiff2 <= $signed({1'b0, b1}) - $signed({1'b0, r1});
				default: hdiff2 <= $signed({1'b0, r1}) - $signed({1'b0, g1});
			endcase
			// stage 3
			h <= hue_c[7:0];     // 0..239
			s <= sat_c;
			v <= max2;
		end
	end

endmodule

/* ycc_to_rgb.sv */
`timescale 1ns/1ps
`include "seg_cfg.svh"

module ycc_to_rgb import seg_pkg::*; (
	input  logic          clk_llc,
	input  logic          resetx,
	input  byte_t         vpo,
	pixel_timing_if.chain tm,
	output chan_t         r,
	output chan_t         g,
	output chan_t         b
);

	localparam logic signed [10:0] KY       = 11'(`K_Y);
	localparam logic signed [10:0] KCRR     = 11'(`K_CR_R);
	localparam logic signed [10:0] KCRG     = 11'(`K_CR_G);
	localparam logic signed [10:0] KCBG     = 11'(`K_CB_G);
	localparam logic signed [10:0] KCBB     = 11'(`K_CB_B);
	localparam logic signed [10:0] Y_OFFSET = 11'(`Y_OFS);
	localparam logic signed [10:0] C_OFFSET = 11'(`C_OFS);

	byte_t              cb_q;       // Cb of the current macropixel
	byte_t              y0_q;       // Y0 of the current macropixel
	logic signed [10:0] y_d;
	logic signed [10:0] cb_d;
	logic signed [10:0] cr_d;
	logic signed [20:0] x_q, a_q, b1_q, b2_q, c_q;   // products
	logic signed [20:0] r_sum, g_sum, b_sum;

	// 8 bit result from 8.10 fixed point, saturating at both ends
	function automatic chan_t clamp8(input logic signed [20:0] sum);
		if (sum[20])
			return 8'd0;
		else if (sum[19:18] != 2'b00)
			return 8'd255;
		else
			return sum[17:10];
	endfunction

	// byte capture, Cr is used straight off the bus
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			cb_q <= '0;
			y0_q <= '0;
		end
		else
		begin
			if (tm.phase == PH_CB)
				cb_q <= vpo;
			if (tm.phase == PH_Y0)
				y0_q <= vpo;
		end
	end

	// x4 scaled, minus black level and chroma zero
	assign y_d  = $signed({1'b0, y0_q, 2'b00}) - Y_OFFSET;
	assign cb_d = $signed({1'b0, cb_q, 2'b00}) - C_OFFSET;
	assign cr_d = $signed({1'b0, vpo, 2'b00}) - C_OFFSET;

	// ------------------------------------------------------------------------
	// stage 1 products, stage 2 sums
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			x_q  <= '0;
			a_q  <= '0;
			b1_q <= '0;
			b2_q <= '0;
			c_q  <= '0;
		end
		else if (tm.sample)
		begin
			x_q  <= KY * y_d;
			a_q  <= KCRR * cr_d;    // red from Cr
			b1_q <= KCRG * cr_d;    // green loses Cr and Cb parts
			b2_q <= KCBG * cb_d;
			c_q  <= KCBB * cb_d;    // blue from Cb
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			r_sum <= '0;
			g_sum <= '0;
			b_sum <= '0;
		end
		else
		begin
			r_sum <= x_q + a_q;
			g_sum <= x_q - b1_q - b2_q;
			b_sum <= x_q + c_q;
		end
	end

	assign r = clamp8(r_sum);
	assign g = clamp8(g_sum);
	assign b = clamp8(b_sum);

endmodule

/* raster_timer.sv */
`timescale 1ns/1ps
`include "seg_cfg.svh"

module raster_timer import seg_pkg::*; (
	input  logic          clk_llc,
	input  logic          resetx,
	input  logic          vref,
	input  logic          href,
	pixel_timing_if.timer tm,
	output logic          frame_done
);

	localparam int LAT = `CLASS_LATENCY;

	logic           href_q;         // for href falling edge
	logic           vref_q;         // for vref falling edge
	logic           line_keep;      // every second line
	logic           active;
	logic           room;           // memory not yet full
	pix_addr_t      pix_cnt;        // next address to store
	logic [LAT-1:0] wr_sr;
	pix_addr_t      addr_sr [LAT];
	logic [LAT:0]   done_sr;

	assign active    = vref & href & line_keep;
	assign room      = (pix_cnt < `FRAME_PIXELS);
	assign tm.sample = active & (tm.phase == PH_CR);

	// ------------------------------------------------------------------------
	// byte phase and line decimation
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			tm.phase  <= PH_CB;
			href_q    <= 1'b0;
			vref_q    <= 1'b0;
			line_keep <= 1'b1;
		end
		else
		begin
			href_q <= href;
			vref_q <= vref;
			if (active)
				tm.phase <= byte_phase_t'(tm.phase + 2'd1);   // Cb Y0 Cr Y1, wraps
			else
				tm.phase <= PH_CB;                             // realign on any gap
			if (!vref)
				line_keep <= 1'b1;          // first line of a frame is kept
			else if (href_q && !href)
				line_keep <= ~line_keep;    // end of line
		end
	end

	// stored pixel counter, stops at the memory size
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			pix_cnt <= '0;
		else if (!vref)
			pix_cnt <= '0;
		else if (tm.sample && room)
			pix_cnt <= pix_cnt + 15'd1;
	end

	// ------------------------------------------------------------------------
	// write strobe and address follow the colour chain latency
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			wr_sr <= '0;
			for (int i = 0; i < LAT; i++)
				addr_sr[i] <= '0;
		end
		else
		begin
			wr_sr      <= {wr_sr[LAT-2:0], tm.sample & room};
			addr_sr[0] <= pix_cnt;
			for (int i = 1; i < LAT; i++)
				addr_sr[i] <= addr_sr[i-1];
		end
	end

	assign tm.wr_en   = wr_sr[LAT-1];
	assign tm.wr_addr = addr_sr[LAT-1];

	// frame end, wait until the last class word is in memory
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			done_sr    <= '0;
			frame_done <= 1'b0;
		end
		else
		begin
			done_sr    <= {done_sr[LAT-1:0], vref_q & ~vref};
			frame_done <= done_sr[LAT];     // LAT+1 edges after vref seen low
		end
	end

	a_wr_range: assert property (@(posedge clk_llc) disable iff (!resetx)
		tm.wr_en |-> (tm.wr_addr < `FRAME_PIXELS))
		else $error("write strobe beyond class memory");

	// Cr sample must follow the Cb and Y0 bytes of the same macropixel
	a_sample_phase: assert property (@(posedge clk_llc) disable iff (!resetx)
		tm.sample |-> (tm.phase == PH_CR) && ($past(tm.phase) == PH_Y0)
			&& ($past(tm.phase, 2) == PH_CB))
		else $error("sample without the Cb and Y0 bytes before it");

endmodule

/* pixel_timing_if.sv */
`timescale 1ns/1ps

// raster timing shared by the timer, the colour chain and the store
interface pixel_timing_if import seg_pkg::*; ();

	byte_phase_t phase;     // which byte of the macropixel is on vpo
	logic        sample;    // Cr of a kept macropixel present
	logic        wr_en;     // sample delayed to line up with the class word
	pix_addr_t   wr_addr;   // address going with wr_en

	// raster_timer side
	modport timer
	(
		output phase,
		output sample,
		output wr_en,
		output wr_addr
	);

	// ycc_to_rgb only needs the byte position
	modport chain (input phase, input sample);

	// class_frame_store write side
	modport store (input wr_en, input wr_addr);

endinterface

/* seg_pkg.sv */
package seg_pkg;

	// one byte of the 4:2:2 stream from the decoder
	typedef logic [7:0] byte_t;

	// r, g, b and h, s, v all travel as 8 bit channels
	typedef logic [7:0] chan_t;

	// frame memory address, 21600 words fit in 15 bits
	typedef logic [14:0] pix_addr_t;

	// class word, bit 5 down to 0 is r o y g b bk
	typedef logic [5:0] class_t;

	// host side word, expanded group mask
	typedef logic [15:0] mask_t;

	// position of a byte inside the macropixel
	typedef enum logic [1:0]
	{
		PH_CB = 2'd0,   // blue difference
		PH_Y0 = 2'd1,   // luma of the pixel we keep
		PH_CR = 2'd2,   // red difference, conversion starts here
		PH_Y1 = 2'd3    // second luma, ignored
	} byte_phase_t;

endpackage

/* seg_cfg.svh */
`ifndef SEG_CFG_SVH
`define SEG_CFG_SVH

// ------------------------------------------------------------------------
// frame and pipeline
// ------------------------------------------------------------------------
`define FRAME_PIXELS  21600     // class memory depth, 180 x 120
`define CLASS_LATENCY 7         // Cr sample edge to valid class word

// ------------------------------------------------------------------------
// YCbCr to RGB, 10 bit constants with 8 fraction bits
// ------------------------------------------------------------------------
`define K_Y    10'd298          // 1.164
`define K_CR_R 10'd408          // 1.596
`define K_CR_G 10'd208          // 0.813
`define K_CB_G 10'd100          // 0.392
`define K_CB_B 10'd516          // 2.017

`define Y_OFS  64               // luma black level, x4 scaled
`define C_OFS  512              // chroma zero, x4 scaled

// ------------------------------------------------------------------------
// colour classes
// ------------------------------------------------------------------------
`define S_THRES_HI 8'd96        // blue needs strong saturation
`define S_THRES_LO 8'd36
`define V_THRES    8'd96
`define HUE_TOL    8'd20        // half width of every hue window

`define HUE_R 8'd220            // hue scale is 0..239
`define HUE_O 8'd20
`define HUE_Y 8'd40
`define HUE_G 8'd85
`define HUE_B 8'd148

`endif
